// ==== all.f ====
hdl/icache_pkg.sv
hdl/boot_rom.sv
hdl/ic_csr.sv
hdl/l1_icache.sv
hdl/l2_line_store.sv
hdl/ic_miss_ctrl.sv
hdl/icache_top.sv
sim/icache_assertions.sv
sim/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # Design, package first
  - files:
      - hdl/icache_pkg.sv
      - hdl/boot_rom.sv
      - hdl/ic_csr.sv
      - hdl/l1_icache.sv
      - hdl/l2_line_store.sv
      - hdl/ic_miss_ctrl.sv
      - hdl/icache_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - sim/icache_assertions.sv
      - sim/tb_icache.sv

// ==== sim/tb_icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 5;
	localparam logic [31:0] MEM_XOR = 32'h5A5A_0000;
	localparam int N_ROM = 4;
	localparam int N_RAND = 12;
	localparam int N_SINGLE = 6;
	// Fetches, invalidates and register accesses in the whole run
	localparam int N_OPS = 1 + N_ROM + 2 * N_RAND + 7 + 2 + N_SINGLE + 6;
	// Lookup, L2 wait, four stalled beats and settle, with margin
	localparam int WORST_CYC = 40;
	localparam longint TIMEOUT_NS = longint'(N_OPS * WORST_CYC + 20) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic [15:0] pc;
	logic inv;
	logic [15:0] inv_adr;
	logic csr_we;
	logic [1:0] csr_adr;
	logic [15:0] csr_wdat;
	logic ack;
	logic err;
	logic tlbflt;
	logic [31:0] dat;
	logic insn_vld;
	logic [31:0] insn;
	logic [1:0] fault;
	logic [15:0] csr_rdat;
	logic cyc;
	logic stb;
	logic [2:0] cti;
	logic [15:0] adr;

	// Reference model state
	logic [15:0] l1_vld;
	logic [7:0] l1_tag [16];
	logic [63:0] l2_vld;
	logic [5:0] l2_tag [64];
	int miss_cnt;
	int fill_cnt;
	logic single_mode;

	// Bus monitor and slave state
	logic bus_seen;
	int stb_rises;
	logic stb_q;
	logic [15:0] stim_lfsr;
	logic [15:0] bus_lfsr;
	logic [15:0] bus_r;
	logic [1:0] stall;
	logic armed;

	icache_top #(.ADDR_W(16), .L1_LINES(16), .L2_LINES(64)) dut (
		.clk(clk), .rst_i(rst), .pc_i(pc), .inv_i(inv), .inv_adr_i(inv_adr),
		.csr_we_i(csr_we), .csr_adr_i(csr_adr), .csr_wdat_i(csr_wdat),
		.ack_i(ack), .err_i(err), .tlbflt_i(tlbflt), .dat_i(dat),
		.insn_vld_o(insn_vld), .insn_o(insn), .fault_o(fault), .csr_rdat_o(csr_rdat),
		.cyc_o(cyc), .stb_o(stb), .cti_o(cti), .adr_o(adr)
	);

	bind ic_miss_ctrl icache_assertions #(.ADDR_W(ADDR_W)) u_bus_checks (
		.clk(clk), .rst_i(rst_i), .cyc_i(cyc_o), .stb_i(stb_o), .adr_i(adr_o),
		.ack_i(ack_i), .err_i(err_i), .tlbflt_i(tlbflt_i), .l1_wr_i(l1_wr_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ========================================
	// Random source and address rules
	// ========================================
	// 16 bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per bit taken
	task automatic take_bits(inout logic [15:0] st, input int n, output logic [15:0] r);
		r = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			r = {r[14:0], st[0]};
		end
	endtask

	function automatic logic is_rom(input logic [15:0] a);
		return a[15:12] == 4'hF;
	endfunction

	// Fault windows, each a whole number of lines
	function automatic logic [1:0] expected_fault(input logic [15:0] a);
		if (a[15:8] == 8'h40)
			return FLT_BUS;
		else if (a[15:8] == 8'h50)
			return FLT_TLB;
		return FLT_NONE;
	endfunction

	function automatic logic [31:0] expected_word(input logic [15:0] a);
		if (is_rom(a))
			return {18'd0, a[15:2]} ^ ROM_XOR;
		else if (expected_fault(a) != FLT_NONE)
			return NOP_WORD;
		return {18'd0, a[15:2]} ^ MEM_XOR;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1, "Check failed");
		end
	endtask

	// ========================================
	// Bus slave and monitor
	// ========================================
	// Answers each beat after 0 to 3 stall cycles
	always @(posedge clk) begin
		#(DRIVE_DLY);
		if (ack || err || tlbflt) begin
			ack = 1'b0;
			err = 1'b0;
			tlbflt = 1'b0;
			armed = 1'b0;
		end else if (stb) begin
			if (!armed) begin
				take_bits(bus_lfsr, 2, bus_r);
				stall = bus_r[1:0];
				armed = 1'b1;
			end
			if (stall == 2'd0) begin
				dat = {18'd0, adr[15:2]} ^ MEM_XOR;
				if (expected_fault(adr) == FLT_BUS)
					err = 1'b1;
				else if (expected_fault(adr) == FLT_TLB)
					tlbflt = 1'b1;
				else
					ack = 1'b1;
			end else begin
				stall = stall - 2'd1;
			end
		end
	end

	always @(negedge clk) begin
		if (cyc)
			bus_seen = 1'b1;
		if (stb && !stb_q)
			stb_rises++;
		stb_q = stb;
		// Single mode never flags a burst
		if (single_mode && cyc)
			check_value("cti_single", 32'd0, {29'd0, cti});
	end

	// ========================================
	// Fetch, invalidate and register access
	// ========================================
	task automatic fetch_and_check(input logic [15:0] a, input string name);
		logic miss;
		logic use_bus;
		logic [31:0] exp_w;
		logic [1:0] exp_f;
		miss = !(l1_vld[a[7:4]] && l1_tag[a[7:4]] == a[15:8]);
		use_bus = miss && !is_rom(a) && !(l2_vld[a[9:4]] && l2_tag[a[9:4]] == a[15:10]);
		exp_w = expected_word(a);
		exp_f = expected_fault(a);
		@(posedge clk);
		#(DRIVE_DLY);
		pc = a;
		bus_seen = 1'b0;
		stb_rises = 0;
		do @(negedge clk); while (!insn_vld);
		check_value(name, exp_w, insn);
		check_value({name, "_fault"}, {30'd0, exp_f}, {30'd0, fault});
		check_value({name, "_bus"}, {31'd0, use_bus}, {31'd0, bus_seen});
		// Burst strobes once, single mode once per beat
		if (use_bus && exp_f == FLT_NONE)
			check_value({name, "_stb"}, single_mode ? 32'd4 : 32'd1, stb_rises);
		if (miss) begin
			miss_cnt++;
			l1_vld[a[7:4]] = 1'b1;
			l1_tag[a[7:4]] = a[15:8];
		end
		if (use_bus) begin
			fill_cnt++;
			// Faulted lines stay out of L2
			if (exp_f == FLT_NONE) begin
				l2_vld[a[9:4]] = 1'b1;
				l2_tag[a[9:4]] = a[15:10];
			end
		end
	endtask

	// Line must be the one just fetched
	task automatic invalidate_line(input logic [15:0] a);
		@(posedge clk);
		#(DRIVE_DLY);
		pc = a;
		inv = 1'b1;
		inv_adr = a;
		@(posedge clk);
		#(DRIVE_DLY);
		inv = 1'b0;
		do @(negedge clk); while (insn_vld);
		l1_vld[a[7:4]] = 1'b0;
	endtask

	task automatic csr_write(input logic [1:0] a, input logic [15:0] d);
		@(posedge clk);
		#(DRIVE_DLY);
		csr_we = 1'b1;
		csr_adr = a;
		csr_wdat = d;
		@(posedge clk);
		#(DRIVE_DLY);
		csr_we = 1'b0;
	endtask

	task automatic csr_check(input logic [1:0] a, input int exp, input string name);
		@(posedge clk);
		#(DRIVE_DLY);
		csr_adr = a;
		@(negedge clk);
		check_value(name, exp, {16'd0, csr_rdat});
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		logic [15:0] r;
		logic [15:0] a;
		// Reset pc sits in ROM so the first miss is a known ROM fill
		pc = 16'hF000;
		inv = 1'b0;
		inv_adr = '0;
		csr_we = 1'b0;
		csr_adr = CSR_CTRL;
		csr_wdat = '0;
		ack = 1'b0;
		err = 1'b0;
		tlbflt = 1'b0;
		dat = '0;
		rst = 1'b1;
		stim_lfsr = 16'd35;
		bus_lfsr = 16'd35;
		l1_vld = '0;
		l2_vld = '0;
		miss_cnt = 0;
		fill_cnt = 0;
		single_mode = 1'b0;
		bus_seen = 1'b0;
		stb_rises = 0;
		stb_q = 1'b0;
		stall = '0;
		armed = 1'b0;
		repeat (10) @(posedge clk);
		#(DRIVE_DLY);
		rst = 1'b0;
		fetch_and_check(16'hF000, "rom_first");

		// ROM region
		for (int i = 0; i < N_ROM; i++) begin
			take_bits(stim_lfsr, 10, r);
			fetch_and_check({4'hF, r[9:0], 2'b00}, "rom_fetch");
		end

		// Random memory lines, then a second word of the same line
		for (int i = 0; i < N_RAND; i++) begin
			take_bits(stim_lfsr, 12, r);
			a = {2'b00, r[11:0], 2'b00};
			fetch_and_check(a, "mem_fetch");
			take_bits(stim_lfsr, 2, r);
			fetch_and_check({a[15:4], r[1:0], 2'b00}, "mem_repeat");
		end

		// Refill from L2 after an invalidate
		fetch_and_check(16'h3A48, "fresh_line");
		invalidate_line(16'h3A48);
		fetch_and_check(16'h3A48, "l2_refetch");

		// Fault windows, faulted lines go back to the bus
		fetch_and_check(16'h4024, "err_fetch");
		fetch_and_check(16'h50C8, "tlb_fetch");
		invalidate_line(16'h50C8);
		fetch_and_check(16'h50C8, "tlb_refetch");

		// Single beat mode
		csr_write(CSR_CTRL, 16'h0000);
		single_mode = 1'b1;
		for (int i = 0; i < N_SINGLE; i++) begin
			take_bits(stim_lfsr, 12, r);
			fetch_and_check({2'b01, r[11:0], 2'b00} | 16'h2000, "single_fetch");
		end
		csr_write(CSR_CTRL, 16'h0001);
		single_mode = 1'b0;

		// Counters against the model, then cleared
		csr_check(CSR_MISS, miss_cnt, "csr_miss");
		csr_check(CSR_FILL, fill_cnt, "csr_fill");
		csr_write(CSR_MISS, 16'h0000);
		csr_write(CSR_FILL, 16'h0000);
		csr_check(CSR_MISS, 0, "csr_miss_clear");
		csr_check(CSR_FILL, 0, "csr_fill_clear");

		$display("ALL TESTS PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("ERROR: watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire

// ==== sim/icache_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_assertions #(
	parameter int ADDR_W = 16
) (
	input wire               clk,
	input wire               rst_i,
	input wire               cyc_i,
	input wire               stb_i,
	input wire [ADDR_W-1:0]  adr_i,
	input wire               ack_i,
	input wire               err_i,
	input wire               tlbflt_i,
	input wire               l1_wr_i
);

	// ========================================
	// Bus protocol
	// ========================================
	// A strobe only inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
		stb_i |-> cyc_i)
		else $error("stb_o high outside a bus cycle");

	// Address holds while a beat is stalled
	a_adr_stable: assert property (@(posedge clk) disable iff (rst_i)
		(stb_i && !(ack_i || err_i || tlbflt_i)) |=> $stable(adr_i))
		else $error("adr_o changed during a stalled beat");

	// L1 write is a single pulse
	a_wr_pulse: assert property (@(posedge clk) disable iff (rst_i)
		l1_wr_i |=> !l1_wr_i)
		else $error("l1_wr high for two cycles");

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_top import icache_pkg::*; #(
	parameter int ADDR_W        = 16,
	parameter int L1_LINES      = 16,
	parameter int L2_LINES      = 64,
	parameter int ROM_BASE_BITS = 4,
	parameter int ROM_LAT       = 1,
	parameter int L2_LAT        = 3,
	parameter int L1_WR_LAT     = 2
) (
	input  wire                clk,
	input  wire                rst_i,
	input  wire [ADDR_W-1:0]   pc_i,
	input  wire                inv_i,
	input  wire [ADDR_W-1:0]   inv_adr_i,
	input  wire                csr_we_i,
	input  wire [1:0]          csr_adr_i,
	input  wire [15:0]         csr_wdat_i,
	input  wire                ack_i,
	input  wire                err_i,
	input  wire                tlbflt_i,
	input  wire [WORD_W-1:0]   dat_i,
	output logic               insn_vld_o,
	output logic [WORD_W-1:0]  insn_o,
	output fault_e             fault_o,
	output logic [15:0]        csr_rdat_o,
	output logic               cyc_o,
	output logic               stb_o,
	output logic [2:0]         cti_o,
	output logic [ADDR_W-1:0]  adr_o
);

	// Controller to arrays
	logic [ADDR_W-1:0]  l1_adr;
	logic [LINE_W-1:0]  l1_line;
	fault_e             l1_fault;
	logic               l1_wr;
	logic               l1_inv;
	logic               l2_rd;
	logic               l2_wr;
	// Arrays back to controller
	logic [LINE_W-1:0]  rom_line;
	logic               l2_vld;
	logic               l2_hit;
	logic [LINE_W-1:0]  l2_line;
	// Register block
	logic               miss_stb;
	logic               fill_stb;
	logic               burst_en;

	// L1 hit doubles as the CPU valid
	ic_miss_ctrl #(
		.ADDR_W(ADDR_W), .ROM_BASE_BITS(ROM_BASE_BITS), .ROM_LAT(ROM_LAT),
		.L2_LAT(L2_LAT), .L1_WR_LAT(L1_WR_LAT)
	) u_ctrl (
		.clk(clk), .rst_i(rst_i), .pc_i(pc_i), .hit_i(insn_vld_o),
		.inv_i(inv_i), .inv_adr_i(inv_adr_i), .burst_en_i(burst_en),
		.rom_line_i(rom_line), .l2_vld_i(l2_vld), .l2_hit_i(l2_hit),
		.l2_line_i(l2_line), .ack_i(ack_i), .err_i(err_i), .tlbflt_i(tlbflt_i),
		.dat_i(dat_i), .l1_adr_o(l1_adr), .l1_line_o(l1_line),
		.l1_fault_o(l1_fault), .l1_wr_o(l1_wr), .l1_inv_o(l1_inv),
		.l2_rd_o(l2_rd), .l2_wr_o(l2_wr), .miss_stb_o(miss_stb),
		.fill_stb_o(fill_stb), .cyc_o(cyc_o), .stb_o(stb_o), .cti_o(cti_o),
		.adr_o(adr_o)
	);

	l1_icache #(.ADDR_W(ADDR_W), .L1_LINES(L1_LINES)) u_l1 (
		.clk(clk), .rst_i(rst_i), .pc_i(pc_i), .wr_i(l1_wr), .inv_i(l1_inv),
		.wadr_i(l1_adr), .wline_i(l1_line), .wfault_i(l1_fault),
		.hit_o(insn_vld_o), .insn_o(insn_o), .fault_o(fault_o)
	);

	l2_line_store #(.ADDR_W(ADDR_W), .L2_LINES(L2_LINES), .L2_LAT(L2_LAT)) u_l2 (
		.clk(clk), .rst_i(rst_i), .rd_i(l2_rd), .wr_i(l2_wr), .adr_i(l1_adr),
		.wline_i(l1_line), .vld_o(l2_vld), .hit_o(l2_hit), .line_o(l2_line)
	);

	boot_rom #(.ADDR_W(ADDR_W)) u_rom (
		.clk(clk), .adr_i(l1_adr), .line_o(rom_line)
	);

	ic_csr u_csr (
		.clk(clk), .rst_i(rst_i), .we_i(csr_we_i), .adr_i(csr_adr_i),
		.wdat_i(csr_wdat_i), .miss_stb_i(miss_stb), .fill_stb_i(fill_stb),
		.rdat_o(csr_rdat_o), .burst_en_o(burst_en)
	);

endmodule

`default_nettype wire

// ==== hdl/ic_miss_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module ic_miss_ctrl import icache_pkg::*; #(
	parameter int ADDR_W        = 16,
	parameter int ROM_BASE_BITS = 4,
	parameter int ROM_LAT       = 1,
	parameter int L2_LAT        = 3,
	parameter int L1_WR_LAT     = 2
) (
	input  wire                clk,
	input  wire                rst_i,
	input  wire [ADDR_W-1:0]   pc_i,
	input  wire                hit_i,
	input  wire                inv_i,
	input  wire [ADDR_W-1:0]   inv_adr_i,
	input  wire                burst_en_i,
	input  wire [LINE_W-1:0]   rom_line_i,
	input  wire                l2_vld_i,
	input  wire                l2_hit_i,
	input  wire [LINE_W-1:0]   l2_line_i,
	input  wire                ack_i,
	input  wire                err_i,
	input  wire                tlbflt_i,
	input  wire [WORD_W-1:0]   dat_i,
	output logic [ADDR_W-1:0]  l1_adr_o,
	output logic [LINE_W-1:0]  l1_line_o,
	output fault_e             l1_fault_o,
	output logic               l1_wr_o,
	output logic               l1_inv_o,
	output logic               l2_rd_o,
	output logic               l2_wr_o,
	output logic               miss_stb_o,
	output logic               fill_stb_o,
	output logic               cyc_o,
	output logic               stb_o,
	output logic [2:0]         cti_o,
	output logic [ADDR_W-1:0]  adr_o
);

	localparam int OFS_W = $clog2(LINE_W / 8);
	localparam int BEAT_W = $clog2(LINE_WORDS);
	localparam logic [BEAT_W-1:0] BEAT_LAST = BEAT_W'(LINE_WORDS - 1);
	// One counter covers ROM wait, L2 guard and write settle
	localparam int CNT_A = (ROM_LAT > L2_LAT) ? ROM_LAT : L2_LAT;
	localparam int CNT_MAX = (CNT_A > L1_WR_LAT) ? CNT_A : L1_WR_LAT;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	// Cycle type identifiers
	localparam logic [2:0] CTI_CLASSIC = 3'b000;
	localparam logic [2:0] CTI_INCR    = 3'b010;
	localparam logic [2:0] CTI_EOB     = 3'b111;

	typedef enum logic [2:0] {
		S_IDLE, S_LOOKUP, S_L2_WAIT, S_BUS_ACK, S_BUS_GAP, S_WRITE, S_SETTLE
	} state_e;

	state_e              state;
	logic [CNT_W-1:0]    cnt;
	logic [BEAT_W-1:0]   beat;
	logic                inv_pend;
	logic [ADDR_W-1:0]   inv_adr_q;
	logic                burst_q;
	logic                from_bus;
	logic                rom_sel;
	logic                beat_done;
	logic                beat_flt;

	// ROM region is the top of the map
	assign rom_sel = &l1_adr_o[ADDR_W-1 -: ROM_BASE_BITS];
	assign beat_flt = err_i | tlbflt_i;
	assign beat_done = ack_i | beat_flt;

	// Single-cycle pulses decoded from the state
	assign l2_rd_o = (state == S_LOOKUP) && !rom_sel;
	assign l1_wr_o = (state == S_WRITE);
	// Faulted bus fills count as fills too
	assign fill_stb_o = l1_wr_o && from_bus;
	// Only clean bus data goes into L2
	assign l2_wr_o = fill_stb_o && (l1_fault_o == FLT_NONE);

	// ========================================
	// Miss sequencer
	// ========================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= S_IDLE;
			cnt <= '0;
			beat <= '0;
			inv_pend <= 1'b0;
			l1_inv_o <= 1'b0;
			miss_stb_o <= 1'b0;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			cti_o <= CTI_CLASSIC;
		end else begin
			l1_inv_o <= 1'b0;
			miss_stb_o <= 1'b0;
			case (state)
			S_IDLE: begin
				cnt <= '0;
				// Invalidate wins over a miss
				if (inv_pend) begin
					l1_adr_o <= {inv_adr_q[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
					l1_inv_o <= 1'b1;
					inv_pend <= 1'b0;
				end else if (!hit_i) begin
					l1_adr_o <= {pc_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
					miss_stb_o <= 1'b1;
					state <= S_LOOKUP;
				end
			end
			S_LOOKUP: begin
				// Non-ROM lines fire the L2 read right here
				if (!rom_sel) begin
					cnt <= '0;
					state <= S_L2_WAIT;
				end else if (cnt == CNT_W'(ROM_LAT)) begin
					l1_line_o <= rom_line_i;
					l1_fault_o <= FLT_NONE;
					from_bus <= 1'b0;
					state <= S_WRITE;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			S_L2_WAIT: begin
				if (l2_vld_i && l2_hit_i) begin
					l1_line_o <= l2_line_i;
					l1_fault_o <= FLT_NONE;
					from_bus <= 1'b0;
					state <= S_WRITE;
				end else if (l2_vld_i || cnt == CNT_W'(L2_LAT - 1)) begin
					// L2 miss, or no answer in time; go to the bus
					cyc_o <= 1'b1;
					stb_o <= 1'b1;
					cti_o <= burst_en_i ? CTI_INCR : CTI_CLASSIC;
					burst_q <= burst_en_i;
					adr_o <= l1_adr_o;
					beat <= '0;
					l1_fault_o <= FLT_NONE;
					from_bus <= 1'b1;
					state <= S_BUS_ACK;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			S_BUS_ACK: begin
				if (beat_done) begin
					beat <= beat + 1'b1;
					adr_o <= adr_o + ADDR_W'(WORD_W / 8);
					if (beat_flt) begin
						l1_line_o <= {LINE_WORDS{NOP_WORD}};
						l1_fault_o <= tlbflt_i ? FLT_TLB : FLT_BUS;
					end else begin
						l1_line_o[beat*WORD_W +: WORD_W] <= dat_i;
					end
					// Fault or last beat closes the cycle
					if (beat_flt || beat == BEAT_LAST) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						cti_o <= CTI_CLASSIC;
						state <= S_WRITE;
					end else if (!burst_q) begin
						stb_o <= 1'b0;
						state <= S_BUS_GAP;
					end else if (beat == BEAT_LAST - 1'b1) begin
						cti_o <= CTI_EOB;
					end
				end
			end
			S_BUS_GAP: begin
				// Single mode; re-strobe once the slave drops ack
				if (!ack_i) begin
					stb_o <= 1'b1;
					state <= S_BUS_ACK;
				end
			end
			S_WRITE: begin
				cnt <= '0;
				state <= S_SETTLE;
			end
			S_SETTLE: begin
				if (cnt == CNT_W'(L1_WR_LAT - 1)) begin
					state <= S_IDLE;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			default: state <= S_IDLE;
			endcase
			// A fresh strobe is kept even if the old one was taken now
			if (inv_i) begin
				inv_pend <= 1'b1;
				inv_adr_q <= inv_adr_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/l2_line_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module l2_line_store import icache_pkg::*; #(
	parameter int ADDR_W   = 16,
	parameter int L2_LINES = 64,
	parameter int L2_LAT   = 3
) (
	input  wire                clk,
	input  wire                rst_i,
	input  wire                rd_i,
	input  wire                wr_i,
	input  wire [ADDR_W-1:0]   adr_i,
	input  wire [LINE_W-1:0]   wline_i,
	output logic               vld_o,
	output logic               hit_o,
	output logic [LINE_W-1:0]  line_o
);

	localparam int OFS_W = $clog2(LINE_W / 8);
	localparam int IDX_W = $clog2(L2_LINES);
	localparam int TAG_W = ADDR_W - IDX_W - OFS_W;

	logic [L2_LINES-1:0]  valid;
	logic [TAG_W-1:0]     tag_mem [L2_LINES];
	logic [LINE_W-1:0]    data_mem [L2_LINES];
	logic [IDX_W-1:0]     idx;
	logic [TAG_W-1:0]     tag;

	// Lookup pipeline, stage 0 first
	logic [L2_LAT-1:0]    vld_pipe;
	logic [L2_LAT-1:0]    hit_pipe;
	logic [LINE_W-1:0]    line_pipe [L2_LAT];

	assign idx = adr_i[OFS_W +: IDX_W];
	assign tag = adr_i[ADDR_W-1 -: TAG_W];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid <= '0;
			vld_pipe <= '0;
			hit_pipe <= '0;
		end else begin
			if (wr_i) begin
				valid[idx] <= 1'b1;
			end
			vld_pipe[0] <= rd_i;
			hit_pipe[0] <= valid[idx] && (tag_mem[idx] == tag);
			for (int i = 1; i < L2_LAT; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
				hit_pipe[i] <= hit_pipe[i-1];
			end
		end
	end

	// Arrays and line data
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[idx] <= tag;
			data_mem[idx] <= wline_i;
		end
		line_pipe[0] <= data_mem[idx];
		for (int i = 1; i < L2_LAT; i++) begin
			line_pipe[i] <= line_pipe[i-1];
		end
	end

	assign vld_o = vld_pipe[L2_LAT-1];
	assign hit_o = hit_pipe[L2_LAT-1];
	assign line_o = line_pipe[L2_LAT-1];

endmodule

`default_nettype wire

// ==== hdl/l1_icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1_icache import icache_pkg::*; #(
	parameter int ADDR_W   = 16,
	parameter int L1_LINES = 16
) (
	input  wire                clk,
	input  wire                rst_i,
	input  wire [ADDR_W-1:0]   pc_i,
	input  wire                wr_i,
	input  wire                inv_i,
	input  wire [ADDR_W-1:0]   wadr_i,
	input  wire [LINE_W-1:0]   wline_i,
	input  wire fault_e        wfault_i,
	output logic               hit_o,
	output logic [WORD_W-1:0]  insn_o,
	output fault_e             fault_o
);

	// Address split: tag | index | word | byte
	localparam int BYTE_W = $clog2(WORD_W / 8);
	localparam int WSEL_W = $clog2(LINE_WORDS);
	localparam int OFS_W = BYTE_W + WSEL_W;
	localparam int IDX_W = $clog2(L1_LINES);
	localparam int TAG_W = ADDR_W - IDX_W - OFS_W;

	logic [L1_LINES-1:0]  valid;
	logic [TAG_W-1:0]     tag_mem [L1_LINES];
	fault_e               flt_mem [L1_LINES];
	logic [LINE_W-1:0]    data_mem [L1_LINES];

	logic [IDX_W-1:0]     p_idx;
	logic [TAG_W-1:0]     p_tag;
	logic [WSEL_W-1:0]    p_wsel;
	logic [IDX_W-1:0]     w_idx;
	logic [TAG_W-1:0]     w_tag;

	assign p_idx = pc_i[OFS_W +: IDX_W];
	assign p_tag = pc_i[ADDR_W-1 -: TAG_W];
	assign p_wsel = pc_i[BYTE_W +: WSEL_W];
	assign w_idx = wadr_i[OFS_W +: IDX_W];
	assign w_tag = wadr_i[ADDR_W-1 -: TAG_W];

	// ========================================
	// Valid bits
	// ========================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid <= '0;
		end else if (wr_i) begin
			valid[w_idx] <= 1'b1;
		end else if (inv_i && tag_mem[w_idx] == w_tag) begin
			// Drop only if the slot still holds that line
			valid[w_idx] <= 1'b0;
		end
	end

	// Tag, fault and data arrays
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[w_idx] <= w_tag;
			flt_mem[w_idx] <= wfault_i;
			data_mem[w_idx] <= wline_i;
		end
	end

	// Fetch side is fully combinational
	assign hit_o = valid[p_idx] && (tag_mem[p_idx] == p_tag);
	assign insn_o = data_mem[p_idx][p_wsel*WORD_W +: WORD_W];
	assign fault_o = flt_mem[p_idx];

endmodule

`default_nettype wire

// ==== hdl/ic_csr.sv ====
`timescale 1ns/100ps
`default_nettype none

module ic_csr import icache_pkg::*; (
	input  wire          clk,
	input  wire          rst_i,
	input  wire          we_i,
	input  wire [1:0]    adr_i,
	input  wire [15:0]   wdat_i,
	input  wire          miss_stb_i,
	input  wire          fill_stb_i,
	output logic [15:0]  rdat_o,
	output logic         burst_en_o
);

	// Counter 0 counts misses, counter 1 bus fills
	localparam logic [1:0] CNT_ADR [2] = '{CSR_MISS, CSR_FILL};

	logic [15:0] ctrl_q;
	logic [15:0] cnt_q [2];
	logic [1:0]  cnt_stb;

	assign cnt_stb = {fill_stb_i, miss_stb_i};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			// Burst on by default
			ctrl_q <= 16'h0001;
			cnt_q <= '{default: '0};
		end else begin
			if (we_i && adr_i == CSR_CTRL) begin
				ctrl_q <= wdat_i;
			end
			for (int i = 0; i < 2; i++) begin
				if (we_i && adr_i == CNT_ADR[i]) begin
					cnt_q[i] <= '0;
				end else if (cnt_stb[i] && cnt_q[i] != 16'hFFFF) begin
					// Saturate instead of wrapping
					cnt_q[i] <= cnt_q[i] + 16'd1;
				end
			end
		end
	end

	assign burst_en_o = ctrl_q[0];

	always_comb begin
		case (adr_i)
		CSR_CTRL: rdat_o = ctrl_q;
		CSR_MISS: rdat_o = cnt_q[0];
		CSR_FILL: rdat_o = cnt_q[1];
		default:  rdat_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/boot_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module boot_rom import icache_pkg::*; #(
	parameter int ADDR_W = 16
) (
	input  wire                clk,
	input  wire [ADDR_W-1:0]   adr_i,
	output logic [LINE_W-1:0]  line_o
);

	localparam int OFS_W = $clog2(LINE_W / 8);
	localparam int WSEL_W = $clog2(LINE_WORDS);

	logic [LINE_W-1:0] line_d;

	// Each word is its own word address, scrambled
	for (genvar w = 0; w < LINE_WORDS; w++) begin : g_word
		assign line_d[w*WORD_W +: WORD_W] =
			WORD_W'({adr_i[ADDR_W-1:OFS_W], WSEL_W'(w)}) ^ ROM_XOR;
	end

	// One cycle read, like a real block ROM
	always_ff @(posedge clk) begin
		line_o <= line_d;
	end

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// ========================================
	// Line geometry
	// ========================================
	localparam int WORD_W = 32;
	localparam int LINE_WORDS = 4;
	localparam int LINE_W = WORD_W * LINE_WORDS;

	// Fault code stored with every L1 line
	typedef enum logic [1:0] {
		FLT_NONE = 2'd0,
		FLT_TLB  = 2'd1,
		FLT_BUS  = 2'd2
	} fault_e;

	// Filler for every word of a faulted line
	localparam logic [WORD_W-1:0] NOP_WORD = 32'h0000_0013;

	// Boot ROM word = zero-extended word address ^ ROM_XOR
	localparam logic [WORD_W-1:0] ROM_XOR = 32'hC0DE_0000;

	// Register map
	localparam logic [1:0] CSR_CTRL = 2'd0;
	localparam logic [1:0] CSR_MISS = 2'd1;
	localparam logic [1:0] CSR_FILL = 2'd2;

endpackage

`default_nettype wire
